/* rtl/display_pkg.sv */
/* constants for a 640x480 display with a 160x120 mono framebuffer
   screen coordinates are signed and blanking runs below zero on both axes */
`default_nettype none

package display_pkg;

    // screen coordinates
    localparam int cordw = 16;  // signed coordinate width in bits

    // horizontal timing in pixels
    // active pixels start at 0 and blanking counts up from h_sta
    localparam int h_sta  = -160;  // first blanking pixel
    localparam int hs_sta = -144;  // hsync goes low
    localparam int hs_end = -48;   // hsync back high
    localparam int ha_end = 639;   // last active pixel

    // vertical timing in lines
    localparam int v_sta  = -45;  // first blanking line
    localparam int vs_sta = -35;  // vsync goes low
    localparam int vs_end = -33;  // vsync back high
    localparam int va_end = 479;  // last active line

    // framebuffer geometry
    localparam int fb_width  = 160;                    // pixels per buffer row
    localparam int fb_height = 120;                    // buffer rows
    localparam int fb_pixels = fb_width * fb_height;   // 19200
    localparam int fb_addrw  = $clog2(fb_pixels);      // 15 bits
    localparam int fb_xw     = $clog2(fb_width);       // host x port, 8 bits
    localparam int fb_yw     = $clog2(fb_height);      // host y port, 7 bits

    // read pipeline depth
    // one cycle for the read decision register and one for the block RAM
    localparam int fb_lat = 2;

    // colour
    localparam int chanw = 4;          // bits per channel
    localparam int colrw = 3 * chanw;  // r, g, b packed msb first

    localparam logic [colrw-1:0] bg_colr = 12'h137;  // outside the buffer area

endpackage

`default_nettype wire

/* rtl/display_timing.sv */
/* 640x480 raster with 800x525 total, counters start in blanking at h_sta/v_sta
   all outputs are registered and match sx/sy of the same cycle */
`timescale 1ns/100ps
`default_nettype none

module display_timing (
    input  wire logic                            clk_pix,
    input  wire logic                            rst_n,
    output logic signed [display_pkg::cordw-1:0] sx,      // horizontal position
    output logic signed [display_pkg::cordw-1:0] sy,      // vertical position
    output logic                                 hsync,   // active low
    output logic                                 vsync,   // active low
    output logic                                 de,      // data enable
    output logic                                 frame,   // start of frame pulse
    output logic                                 vblank   // vertical blanking
);
    import display_pkg::*;

    logic signed [cordw-1:0] sx_nxt;  // position for the next cycle
    logic signed [cordw-1:0] sy_nxt;

    // next position, wraps at end of line and end of frame
    always_comb begin
        if (sx == ha_end) begin
            sx_nxt = cordw'(h_sta);  // back to start of blanking
            if (sy == va_end) begin
                sy_nxt = cordw'(v_sta);  // new frame
            end else begin
                sy_nxt = sy + cordw'(1);
            end
        end else begin
            sx_nxt = sx + cordw'(1);
            sy_nxt = sy;
        end
    end

    // decode from the next position so flags line up with sx/sy
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx     <= cordw'(h_sta);
            sy     <= cordw'(v_sta);
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            de     <= 1'b0;
            frame  <= 1'b0;
            vblank <= 1'b1;  // v_sta is a blanking line
        end else begin
            sx     <= sx_nxt;
            sy     <= sy_nxt;
            hsync  <= !(sx_nxt >= hs_sta && sx_nxt < hs_end);  // 96 pixels low
            vsync  <= !(sy_nxt >= vs_sta && sy_nxt < vs_end);  // 2 lines low
            de     <= (sx_nxt >= 0 && sy_nxt >= 0);
            frame  <= (sx_nxt == h_sta && sy_nxt == v_sta);
            vblank <= (sy_nxt < 0);
        end
    end

    // counters stay inside the 800x525 raster
    a_coord_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx >= h_sta && sx <= ha_end && sy >= v_sta && sy <= va_end);

endmodule

`default_nettype wire

/* rtl/fb_writer.sv */
/* host pixel port, ready only in vertical blank so a shown frame never tears
   the host must hold x, y and pixel stable until the transfer
   pixels outside 160x120 complete the handshake but are not written */
`timescale 1ns/100ps
`default_nettype none

module fb_writer (
    input  wire logic                              clk_pix,
    input  wire logic                              rst_n,
    input  wire logic                              vblank,     // from timing
    input  wire logic                              wr_valid,
    input  wire logic [display_pkg::fb_xw-1:0]     wr_x,
    input  wire logic [display_pkg::fb_yw-1:0]     wr_y,
    input  wire logic                              wr_pixel,
    output logic                                   wr_ready,
    output logic                                   we,         // to memory
    output logic      [display_pkg::fb_addrw-1:0]  addr_write,
    output logic                                   data_in
);
    import display_pkg::*;

    logic                ready_en;  // low during reset and the cycle after
    logic                xfer;      // handshake completes this edge
    logic                in_buf;    // coordinate lands inside the buffer
    logic [fb_addrw-1:0] addr_lin;  // y * width + x

    assign wr_ready = vblank && ready_en;  // back-pressure for the whole active frame
    assign xfer     = wr_valid && wr_ready;
    assign in_buf   = (wr_x < fb_width) && (wr_y < fb_height);

    // linear address, max 119*160+159 fits in 15 bits
    assign addr_lin = fb_addrw'(wr_y) * fb_addrw'(fb_width) + fb_addrw'(wr_x);

    // control
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            ready_en <= 1'b0;
            we       <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            we       <= xfer && in_buf;  // dropped coordinates give no strobe
        end
    end

    // payload, captured on every transfer
    always_ff @(posedge clk_pix) begin
        if (xfer) begin
            addr_write <= addr_lin;
            data_in    <= wr_pixel;
        end
    end

    // strobe only ever carries a valid buffer address
    a_addr_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        we |-> addr_write < fb_pixels);

endmodule

`default_nettype wire

/* rtl/fb_bram.sv */
/* simple dual-port 19200x1 RAM on one clock, read data one cycle after addr_read
   contents start at zero from an initial block, valid in simulation and on
   FPGAs that load block RAM at configuration */
`timescale 1ns/100ps
`default_nettype none

module fb_bram (
    input  wire logic                             clk_pix,
    input  wire logic                             we,
    input  wire logic [display_pkg::fb_addrw-1:0] addr_write,
    input  wire logic                             data_in,
    input  wire logic [display_pkg::fb_addrw-1:0] addr_read,
    output logic                                  data_out
);
    import display_pkg::*;

    logic mem [fb_pixels];  // one bit per pixel

    // blank buffer at start
    initial begin
        for (int i = 0; i < fb_pixels; i++) begin
            mem[i] = 1'b0;
        end
    end

    // write port
    always @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, read-before-write on address collision
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];
    end

endmodule

`default_nettype wire

/* rtl/fb_scanout.sv */
/* reads the buffer in raster order and paints it in the top-left 160x120
   read address runs fb_lat cycles ahead so data_out matches the current pixel
   outputs are registered once, so vga_* trail sx/sy by one cycle */
`timescale 1ns/100ps
`default_nettype none

module fb_scanout (
    input  wire logic                                   clk_pix,
    input  wire logic                                   rst_n,
    input  wire logic signed [display_pkg::cordw-1:0]   sx,
    input  wire logic signed [display_pkg::cordw-1:0]   sy,
    input  wire logic                                   de,
    input  wire logic                                   hsync,
    input  wire logic                                   vsync,
    input  wire logic                                   frame,
    input  wire logic                                   data_out,   // from memory
    output logic             [display_pkg::fb_addrw-1:0] addr_read, // to memory
    output logic                                        vga_hsync,
    output logic                                        vga_vsync,
    output logic             [display_pkg::chanw-1:0]   vga_r,
    output logic             [display_pkg::chanw-1:0]   vga_g,
    output logic             [display_pkg::chanw-1:0]   vga_b
);
    import display_pkg::*;

    logic             read_fb;       // address advances this cycle
    logic             paint_area;    // pixel inside the buffer
    logic [colrw-1:0] paint_colr;    // buffer or background
    logic [colrw-1:0] display_colr;  // black while blanking

    // read decision and address counter
    // decision starts fb_lat pixels early, one for this register and one for the RAM
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            read_fb   <= 1'b0;
            addr_read <= '0;
        end else begin
            read_fb <= (sy >= 0 && sy < fb_height &&
                        sx >= -fb_lat && sx < fb_width - fb_lat);
            if (frame) begin
                addr_read <= '0;  // restart each frame
            end else if (read_fb) begin
                if (addr_read == fb_addrw'(fb_pixels - 1)) begin
                    addr_read <= '0;  // last pixel, park at zero until next frame
                end else begin
                    addr_read <= addr_read + 1'b1;
                end
            end
        end
    end

    // paint
    always_comb begin
        paint_area = (sy >= 0 && sy < fb_height && sx >= 0 && sx < fb_width);
        if (paint_area) begin
            paint_colr = {colrw{data_out}};  // 1 -> fff, 0 -> 000
        end else begin
            paint_colr = bg_colr;
        end
        display_colr = de ? paint_colr : '0;
    end

    // VGA output registers
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync;
            vga_vsync <= vsync;
            {vga_r, vga_g, vga_b} <= display_colr;
        end
    end

    // read address never runs past the buffer
    a_addr_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        addr_read < fb_pixels);

    // buffer row fully read by the time the row is painted
    a_row_end: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (sy >= 0 && sy < fb_height && sx == fb_width) |->
        addr_read == fb_addrw'(((sy + 1) * fb_width) % fb_pixels));

endmodule

`default_nettype wire

/* rtl/display_top.sv */
/* mono framebuffer display on a single pixel clock, clk_pix and rst_n from outside
   host writes are accepted only while wr_ready is high during vertical blank */
`timescale 1ns/100ps
`default_nettype none

module display_top (
    input  wire logic                          clk_pix,    // 25.2 MHz nominal
    input  wire logic                          rst_n,
    input  wire logic                          wr_valid,
    input  wire logic [display_pkg::fb_xw-1:0] wr_x,
    input  wire logic [display_pkg::fb_yw-1:0] wr_y,
    input  wire logic                          wr_pixel,
    output logic                               wr_ready,
    output logic                               vga_hsync,
    output logic                               vga_vsync,
    output logic      [display_pkg::chanw-1:0] vga_r,
    output logic      [display_pkg::chanw-1:0] vga_g,
    output logic      [display_pkg::chanw-1:0] vga_b
);
    import display_pkg::*;

    // timing to writer and scan-out
    logic signed [cordw-1:0] sx;
    logic signed [cordw-1:0] sy;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    logic                    frame;
    logic                    vblank;

    // memory ports
    logic                we;
    logic [fb_addrw-1:0] addr_write;
    logic                data_in;
    logic [fb_addrw-1:0] addr_read;
    logic                data_out;

    display_timing i_display_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame),
        .vblank  (vblank)
    );

    fb_writer i_fb_writer (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .vblank     (vblank),
        .wr_valid   (wr_valid),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_pixel   (wr_pixel),
        .wr_ready   (wr_ready),
        .we         (we),
        .addr_write (addr_write),
        .data_in    (data_in)
    );

    fb_bram i_fb_bram (
        .clk_pix    (clk_pix),
        .we         (we),
        .addr_write (addr_write),
        .data_in    (data_in),
        .addr_read  (addr_read),
        .data_out   (data_out)
    );

    fb_scanout i_fb_scanout (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .sx        (sx),
        .sy        (sy),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .frame     (frame),
        .data_out  (data_out),
        .addr_read (addr_read),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

/* bench/display_tb.sv */
/* self-checking bench for display_top, pixel clock period 40 ns
   fills the buffer in the first vertical blank, overwrites part of it in the second
   output position is recovered from the sync falling edges, so lock needs one vsync */
`timescale 1ns/100ps
`default_nettype none

module display_tb;
    import display_pkg::*;

    localparam logic [15:0] seed       = 16'd55162;
    localparam int          wait_limit = 450000;  // a bit over one frame of cycles
    localparam int          n_random   = 200;     // overwrites in the second blank
    localparam int          n_outside  = 8;       // each one for x and one for y

    logic               clk_pix;
    logic               rst_n;
    logic               wr_valid;
    logic [fb_xw-1:0]   wr_x;
    logic [fb_yw-1:0]   wr_y;
    logic               wr_pixel;
    logic               wr_ready;
    logic               vga_hsync;
    logic               vga_vsync;
    logic [chanw-1:0]   vga_r;
    logic [chanw-1:0]   vga_g;
    logic [chanw-1:0]   vga_b;

    logic        shadow [fb_pixels];  // expected buffer contents
    logic [15:0] lfsr;
    logic        aborted;             // a wait ran out, skip the rest
    int          value_errs, timing_errs, protocol_errs, timeouts;
    int          last_wait;           // cycles the last write waited for ready

    // output position tracking
    logic        locked;
    int          out_x, out_y;        // raster position of the current vga sample
    logic        prev_hs, prev_vs;
    logic        hs_seen, vs_seen;
    int          hs_since, hs_low, vs_since, vs_low;
    int          hs_periods, vs_periods, buf_checked, bg_checked;

    display_top i_display_top (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_x      (wr_x),
        .wr_y      (wr_y),
        .wr_pixel  (wr_pixel),
        .wr_ready  (wr_ready),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;  // 25 MHz
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one step per bit taken, msb first
    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // painting rule: black in blanking, buffer in the corner, background elsewhere
    function automatic logic [colrw-1:0] expected_colr(input int x, input int y);
        if (x < 0 || y < 0) return '0;
        if (x < fb_width && y < fb_height) begin
            return shadow[y * fb_width + x] ? 12'hfff : 12'h000;
        end
        return bg_colr;
    endfunction

    // one handshake, called at edge + 2 ns, returns at edge + 2 ns
    task automatic write_pixel(input int x, input int y, input logic p);
        int          waited;
        logic [15:0] gap;
        waited = 0;
        if (!aborted) begin
            draw_bits(1, gap);
            if (gap[0]) begin  // idle cycle before this write
                @(posedge clk_pix);
                #2;
            end
            wr_valid = 1'b1;
            wr_x     = fb_xw'(x);
            wr_y     = fb_yw'(y);
            wr_pixel = p;
            while (!wr_ready && waited < wait_limit) begin
                @(posedge clk_pix);
                #2;
                waited++;
            end
            if (!wr_ready) begin
                timeouts++;
                $display("write to x %0d y %0d was never accepted", x, y);
                aborted  = 1'b1;
                wr_valid = 1'b0;
            end else begin
                @(posedge clk_pix);  // transfer on this edge
                #2;
                wr_valid  = 1'b0;
                last_wait = waited;
            end
        end
    endtask

    // wait until the vga output shows the given line
    task automatic wait_line(input int y);
        int waited;
        waited = 0;
        if (!aborted) begin
            while (!(locked && out_y == y) && waited < wait_limit) begin
                @(posedge clk_pix);
                #2;
                waited++;
            end
            if (!(locked && out_y == y)) begin
                timeouts++;
                $display("vga output never reached line %0d", y);
                aborted = 1'b1;
            end
        end
    endtask

    // comparing process, samples the values held over the cycle before each edge
    always @(posedge clk_pix) begin
        logic [colrw-1:0] got_colr;
        logic [colrw-1:0] exp_colr;
        got_colr = {vga_r, vga_g, vga_b};
        if (rst_n) begin
            if (locked) begin  // step to the position of this sample
                if (out_x == ha_end) begin
                    out_x = h_sta;
                    out_y = (out_y == va_end) ? v_sta : out_y + 1;
                end else begin
                    out_x++;
                end
            end
            if (prev_vs && !vga_vsync) begin
                if (locked) begin
                    assert (out_x == h_sta && out_y == vs_sta) else begin
                        timing_errs++;
                        $display("vsync fell at x %0d y %0d, not at line start", out_x, out_y);
                    end
                end
                if (vs_seen) begin
                    vs_periods++;
                    assert (vs_since == 525 * 800) else begin
                        timing_errs++;
                        $display("error %0d ns: vga_vsync period expected %0d actual %0d",
                                 $time, 525 * 800, vs_since);
                    end
                end
                out_x    = h_sta;
                out_y    = vs_sta;
                locked   = 1'b1;
                vs_seen  = 1'b1;
                vs_since = 0;
            end
            if (prev_hs && !vga_hsync) begin
                if (locked) begin
                    assert (out_x == hs_sta) else begin
                        timing_errs++;
                        $display("error %0d ns: vga_hsync fall at x expected %0d actual %0d",
                                 $time, hs_sta, out_x);
                    end
                end
                if (hs_seen) begin
                    hs_periods++;
                    assert (hs_since == 800) else begin
                        timing_errs++;
                        $display("error %0d ns: vga_hsync period expected 800 actual %0d",
                                 $time, hs_since);
                    end
                end
                hs_seen  = 1'b1;
                hs_since = 0;
            end
            if (!prev_hs && vga_hsync) begin
                assert (hs_low == 96) else begin
                    timing_errs++;
                    $display("error %0d ns: vga_hsync low expected 96 actual %0d",
                             $time, hs_low);
                end
                hs_low = 0;
            end
            if (!prev_vs && vga_vsync) begin
                assert (vs_low == 2 * 800) else begin
                    timing_errs++;
                    $display("error %0d ns: vga_vsync low expected 1600 actual %0d",
                             $time, vs_low);
                end
                vs_low = 0;
            end
            hs_since++;
            vs_since++;
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            exp_colr = locked ? expected_colr(out_x, out_y) : '0;  // before lock still blank
            assert (got_colr == exp_colr) else begin
                value_errs++;
                $display("error %0d ns: {vga_r, vga_g, vga_b} at x %0d y %0d expected %03h actual %03h",
                         $time, out_x, out_y, exp_colr, got_colr);
            end
            if (locked && out_x >= 0 && out_y >= 0) begin
                if (out_x < fb_width && out_y < fb_height) buf_checked++;
                else bg_checked++;
            end
            // ready belongs to the next position, high again only after (639, 479)
            if (locked && out_y >= 0 && !(out_x == ha_end && out_y == va_end)) begin
                assert (!wr_ready) else begin
                    protocol_errs++;
                    $display("wr_ready high during active line %0d", out_y);
                end
            end
            if (wr_valid && wr_ready) begin  // transfer, shadow only keeps buffer hits
                if (wr_x < fb_width && wr_y < fb_height) begin
                    shadow[wr_y * fb_width + wr_x] = wr_pixel;
                end
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
    end

    initial begin
        logic [15:0] rx;
        logic [15:0] ry;
        logic [15:0] rp;
        wr_valid = 1'b0;
        wr_x     = '0;
        wr_y     = '0;
        wr_pixel = 1'b0;
        rst_n    = 1'b0;
        lfsr     = seed;
        aborted  = 1'b0;
        {value_errs, timing_errs, protocol_errs, timeouts} = '0;
        {last_wait, out_x, out_y} = '0;
        {hs_since, hs_low, vs_since, vs_low} = '0;
        {hs_periods, vs_periods, buf_checked, bg_checked} = '0;
        {locked, hs_seen, vs_seen} = '0;
        prev_hs = 1'b1;
        prev_vs = 1'b1;
        for (int i = 0; i < fb_pixels; i++) shadow[i] = 1'b0;  // memory starts cleared

        repeat (16) @(posedge clk_pix);
        #1;
        assert (vga_hsync === 1'b1 && vga_vsync === 1'b1 && {vga_r, vga_g, vga_b} === '0
                && wr_ready === 1'b0) else begin
            protocol_errs++;
            $display("outputs not idle at the end of reset");
        end
        #1;
        rst_n = 1'b1;

        // whole buffer from the LFSR in the first vertical blank
        for (int i = 0; i < fb_pixels && !aborted; i++) begin
            draw_bits(1, rp);
            write_pixel(i % fb_width, i / fb_width, rp[0]);
        end

        // a write raised mid-frame has to wait for the next blank
        wait_line(200);
        draw_bits(fb_xw, rx);
        draw_bits(fb_yw, ry);
        draw_bits(1, rp);
        write_pixel(int'(rx) % fb_width, int'(ry) % fb_height, rp[0]);
        if (!aborted) begin
            assert (last_wait > 0 && (out_y < 0 || out_y == va_end)) else begin
                protocol_errs++;
                $display("write held in an active line completed at line %0d after %0d cycles",
                         out_y, last_wait);
            end
        end

        // second blank, dropped coordinates then random overwrites
        for (int i = 0; i < n_outside; i++) begin
            write_pixel(fb_width + 8 * i + 3, i, 1'b1);
            write_pixel(i, fb_height + i, 1'b1);
        end
        for (int i = 0; i < n_random; i++) begin
            draw_bits(fb_xw, rx);  // about a third of these land beyond x 159
            draw_bits(fb_yw, ry);
            draw_bits(1, rp);
            write_pixel(int'(rx), int'(ry), rp[0]);
        end

        // let the following frame go out in full
        wait_line(va_end);
        wait_line(v_sta);
        if (!aborted) begin
            assert (buf_checked >= 2 * fb_pixels && bg_checked > 0
                    && hs_periods > 1000 && vs_periods >= 1) else begin
                protocol_errs++;
                $display("too little output checked, %0d buffer pixels", buf_checked);
            end
        end

        $display("errors: value %0d, timing %0d, protocol %0d, timeout %0d",
                 value_errs, timing_errs, protocol_errs, timeouts);
        if (value_errs + timing_errs + protocol_errs + timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/display_pkg.sv
rtl/display_timing.sv
rtl/fb_writer.sv
rtl/fb_bram.sv
rtl/fb_scanout.sv
rtl/display_top.sv
bench/display_tb.sv

/* Bender.yml */
package:
  name: mono_display

sources:
  # design, package first
  - files:
      - rtl/display_pkg.sv
      - rtl/display_timing.sv
      - rtl/fb_writer.sv
      - rtl/fb_bram.sv
      - rtl/fb_scanout.sv
      - rtl/display_top.sv

  # testbench
  - target: simulation
    files:
      - bench/display_tb.sv
